//--- design/dsp_pkg.sv
// Datapath constants and types for the single-clock DSP signal path.
// Shared by the FIFO, the FIR engine and the top level through scoped names.

`default_nettype none

package dsp_pkg;

    // ==========================================================
    // Widths
    // ==========================================================
    localparam int DATA_W     = 16;   // Sample and output word
    localparam int COEFF_W    = 16;   // Signed coefficient
    localparam int ACC_W      = 40;   // MAC accumulator with headroom for 8 taps
    localparam int TAPS       = 8;
    localparam int ADDR_W     = 3;    // Coefficient address of log2(TAPS) bits
    localparam int FRAC_BITS  = 15;   // Output shift for Q15 coefficients
    localparam int FIFO_DEPTH = 4;    // Power of two so pointers wrap on their own

    // FIR engine FSM
    typedef enum logic [1:0] {
        FIR_IDLE,   // Waiting for a sample
        FIR_MAC,    // One tap per cycle
        FIR_OUT     // Result on dsp_out
    } fir_state_t;

endpackage

`default_nettype wire

//--- design/ctrl_pkg.sv
// Control-side constants and types: sample divider select and BIST sequencing.
// Used by the sampler, the BIST controller and the top level.

`default_nettype none

package ctrl_pkg;

    // Sample strobe period select
    typedef enum logic [1:0] {DIV_2, DIV_4, DIV_8, DIV_16} div_sel_t;

    // BIST FSM
    typedef enum logic [1:0] {BIST_IDLE, BIST_RUN, BIST_DRAIN, BIST_DONE} bist_state_t;

    localparam int          BIST_PATTERNS = 32;        // Patterns injected per run
    localparam logic [15:0] LFSR_SEED     = 16'hace1;  // Fibonacci LFSR with taps 16 14 13 11
    localparam int          SIG_W         = 16;        // Signature register

endpackage

`default_nettype wire

//--- design/adc_sampler.sv
// ADC front end. An integer divider makes a sample strobe every 2/4/8/16
// clocks and the ADC word is registered on each strobe where it is valid.

`timescale 1ns/1ps
`default_nettype none

module adc_sampler (
    input  wire                       clk,
    input  wire                       reset,
    input  wire ctrl_pkg::div_sel_t   div_sel,
    input  wire [15:0]                adc_data,
    input  wire                       adc_valid,
    output logic [15:0]               cap_data,
    output logic                      cap_valid
);

    ctrl_pkg::div_sel_t div_sel_q;  // Last select, for change detect
    logic [3:0]         cnt;        // Cycle counter
    logic [3:0]         term;       // N-1 for the selected divide
    logic               div_change;
    logic               strobe;

    always_comb begin
        case (div_sel)
            ctrl_pkg::DIV_2:  term = 4'd1;
            ctrl_pkg::DIV_4:  term = 4'd3;
            ctrl_pkg::DIV_8:  term = 4'd7;
            default:          term = 4'd15;
        endcase
    end

    assign div_change = div_sel != div_sel_q;          // New ratio restarts count
    assign strobe     = (cnt == term) && !div_change;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt       <= '0;
            div_sel_q <= div_sel;   // No restart on the first cycle out of reset
            cap_valid <= 1'b0;
        end else begin
            div_sel_q <= div_sel;
            if (strobe || div_change) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            cap_valid <= strobe && adc_valid;  // One cycle after the strobe
        end
    end

    // Capture register
    always_ff @(posedge clk) begin
        if (strobe && adc_valid) begin
            cap_data <= adc_data;
        end
    end

endmodule

`default_nettype wire

//--- design/sample_fifo.sv
// Small same-clock FIFO between the sampler/BIST mux and the FIR engine.
// Head is presented combinationally; writes when full are dropped and flagged.

`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         wr_en,
    input  wire [dsp_pkg::DATA_W-1:0]   wr_data,
    input  wire                         rd_en,
    output logic [dsp_pkg::DATA_W-1:0]  rd_data,
    output logic                        empty,
    output logic                        full,
    output logic                        overrun
);

    typedef logic [$clog2(dsp_pkg::FIFO_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(dsp_pkg::FIFO_DEPTH):0]   cnt_t;  // One extra bit for full

    logic [dsp_pkg::DATA_W-1:0] mem [dsp_pkg::FIFO_DEPTH];
    ptr_t                       wr_ptr;
    ptr_t                       rd_ptr;
    cnt_t                       count;   // Occupancy
    logic                       do_wr;
    logic                       do_rd;

    assign full    = count == cnt_t'(dsp_pkg::FIFO_DEPTH);
    assign empty   = count == '0;
    assign do_wr   = wr_en && !full;    // Full blocks the write even with a read
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];       // Head, same-cycle read

    // ==========================================================
    // Pointers and occupancy
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            overrun <= wr_en && full;             // Dropped word
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- design/fir_engine.sv
// Sequential 8-tap FIR. Pops one sample from the FIFO, runs one MAC per tap
// and presents the Q15-scaled result for one cycle. Coefficients are written
// into a load bank and copied to the active bank on each pop.

`timescale 1ns/1ps
`default_nettype none

module fir_engine (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         fifo_empty,
    input  wire [dsp_pkg::DATA_W-1:0]   fifo_data,
    output logic                        fifo_rd,
    input  wire                         coeff_load,
    input  wire [dsp_pkg::ADDR_W-1:0]   coeff_addr,
    input  wire [dsp_pkg::COEFF_W-1:0]  coeff_data,
    output logic [dsp_pkg::DATA_W-1:0]  dsp_out,
    output logic                        dsp_valid,
    output logic                        busy
);

    typedef logic [dsp_pkg::ADDR_W-1:0]       tap_t;
    typedef logic signed [dsp_pkg::ACC_W-1:0] acc_t;

    dsp_pkg::fir_state_t                  state;
    tap_t                                 tap;         // Tap under MAC
    logic signed [dsp_pkg::COEFF_W-1:0]   coeff_bank [dsp_pkg::TAPS];  // Host writes
    logic signed [dsp_pkg::COEFF_W-1:0]   coeff_act  [dsp_pkg::TAPS];  // In use
    logic signed [dsp_pkg::DATA_W-1:0]    delay      [dsp_pkg::TAPS];  // [0] newest
    logic signed [dsp_pkg::COEFF_W+dsp_pkg::DATA_W-1:0] prod;
    acc_t                                 acc;
    acc_t                                 acc_scaled;

    // ==========================================================
    // Outputs and datapath
    // ==========================================================
    assign fifo_rd    = (state == dsp_pkg::FIR_IDLE) && !fifo_empty;  // Pop cycle 0
    assign busy       = state != dsp_pkg::FIR_IDLE;                   // Cycles 1 to 9
    assign dsp_valid  = state == dsp_pkg::FIR_OUT;                    // Cycle 9
    assign prod       = coeff_act[tap] * delay[tap];                  // Signed 16x16
    assign acc_scaled = acc >>> dsp_pkg::FRAC_BITS;
    assign dsp_out    = acc_scaled[dsp_pkg::DATA_W-1:0];              // Keep low word

    // FSM and accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dsp_pkg::FIR_IDLE;
            tap   <= '0;
            acc   <= '0;
        end else begin
            case (state)
                dsp_pkg::FIR_IDLE: begin
                    if (fifo_rd) begin
                        state <= dsp_pkg::FIR_MAC;
                        tap   <= '0;
                        acc   <= '0;       // Fresh sum per sample
                    end
                end
                dsp_pkg::FIR_MAC: begin
                    acc <= acc + acc_t'(prod);  // Sign-extended product
                    tap <= tap + 1'b1;
                    if (tap == tap_t'(dsp_pkg::TAPS - 1)) begin
                        state <= dsp_pkg::FIR_OUT;
                    end
                end
                dsp_pkg::FIR_OUT: state <= dsp_pkg::FIR_IDLE;
                default:          state <= dsp_pkg::FIR_IDLE;
            endcase
        end
    end

    // ==========================================================
    // Coefficient banks and delay line
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < dsp_pkg::TAPS; k++) begin
                coeff_bank[k] <= '0;
                coeff_act[k]  <= '0;
                delay[k]      <= '0;
            end
        end else begin
            if (coeff_load) begin
                coeff_bank[coeff_addr] <= coeff_data;
            end
            if (fifo_rd) begin
                delay[0] <= fifo_data;                      // Newest sample in
                for (int k = 1; k < dsp_pkg::TAPS; k++) begin
                    delay[k] <= delay[k-1];
                end
                for (int k = 0; k < dsp_pkg::TAPS; k++) begin
                    coeff_act[k] <= coeff_bank[k];           // Loads take effect here
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/bist_ctrl.sv
// BIST controller. Injects a fixed run of LFSR patterns into the FIFO in
// place of ADC data, then folds every filter output into a rotate-XOR signature.

`timescale 1ns/1ps
`default_nettype none

module bist_ctrl (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          bist_start,
    input  wire [dsp_pkg::DATA_W-1:0]    cap_data,
    input  wire                          cap_valid,
    input  wire                          fifo_full,
    input  wire                          fifo_empty,
    input  wire                          fir_busy,
    input  wire [dsp_pkg::DATA_W-1:0]    dsp_out,
    input  wire                          dsp_valid,
    output logic                         wr_en,
    output logic [dsp_pkg::DATA_W-1:0]   wr_data,
    output logic                         bist_active,
    output logic                         bist_done,
    output logic [ctrl_pkg::SIG_W-1:0]   bist_signature
);

    typedef logic [$clog2(ctrl_pkg::BIST_PATTERNS)-1:0] pat_cnt_t;

    ctrl_pkg::bist_state_t      state;
    logic [15:0]                lfsr;       // Pattern source
    logic                       lfsr_fb;
    pat_cnt_t                   pat_cnt;    // Patterns written so far
    logic                       pat_wr;
    logic                       adc_pass;   // Sampler owns the FIFO input
    logic [ctrl_pkg::SIG_W-1:0] signature;

    assign lfsr_fb  = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Taps 16 14 13 11
    assign pat_wr   = (state == ctrl_pkg::BIST_RUN) && !fifo_full;
    assign adc_pass = (state == ctrl_pkg::BIST_IDLE) || (state == ctrl_pkg::BIST_DONE);
    assign wr_en    = pat_wr || (adc_pass && cap_valid);
    assign wr_data  = (state == ctrl_pkg::BIST_RUN) ? lfsr : cap_data;

    assign bist_active    = (state == ctrl_pkg::BIST_RUN) || (state == ctrl_pkg::BIST_DRAIN);
    assign bist_done      = state == ctrl_pkg::BIST_DONE;
    assign bist_signature = signature;

    // ==========================================================
    // Sequencer, LFSR and signature
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ctrl_pkg::BIST_IDLE;
            lfsr      <= ctrl_pkg::LFSR_SEED;
            pat_cnt   <= '0;
            signature <= '0;
        end else begin
            case (state)
                ctrl_pkg::BIST_IDLE, ctrl_pkg::BIST_DONE: begin
                    if (bist_start) begin
                        state     <= ctrl_pkg::BIST_RUN;
                        lfsr      <= ctrl_pkg::LFSR_SEED;  // Same run every time
                        pat_cnt   <= '0;
                        signature <= '0;
                    end
                end
                ctrl_pkg::BIST_RUN: begin
                    if (pat_wr) begin
                        lfsr    <= {lfsr[14:0], lfsr_fb};  // Advance per write
                        pat_cnt <= pat_cnt + 1'b1;
                        if (pat_cnt == pat_cnt_t'(ctrl_pkg::BIST_PATTERNS - 1)) begin
                            state <= ctrl_pkg::BIST_DRAIN;
                        end
                    end
                end
                ctrl_pkg::BIST_DRAIN: begin
                    if (fifo_empty && !fir_busy) state <= ctrl_pkg::BIST_DONE;  // All out
                end
                default: state <= ctrl_pkg::BIST_IDLE;
            endcase
            if (bist_active && dsp_valid) begin
                signature <= {signature[ctrl_pkg::SIG_W-2:0], signature[ctrl_pkg::SIG_W-1]}
                             ^ dsp_out;              // Rotate left then fold
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dsp_top.sv
// Top level of the single-clock DSP path: ADC sampler, BIST input mux,
// sample FIFO and FIR engine. Instances and wiring only.

`timescale 1ns/1ps
`default_nettype none

module dsp_top (
    input  wire                          clk,
    input  wire                          reset,
    input  wire ctrl_pkg::div_sel_t      div_sel,
    input  wire [dsp_pkg::DATA_W-1:0]    adc_data,
    input  wire                          adc_valid,
    input  wire                          coeff_load,
    input  wire [dsp_pkg::ADDR_W-1:0]    coeff_addr,
    input  wire [dsp_pkg::COEFF_W-1:0]   coeff_data,
    input  wire                          bist_start,
    output logic [dsp_pkg::DATA_W-1:0]   dsp_out,
    output logic                         dsp_valid,
    output logic                         dsp_busy,
    output logic                         overrun,
    output logic                         bist_active,
    output logic                         bist_done,
    output logic [ctrl_pkg::SIG_W-1:0]   bist_signature
);

    logic [dsp_pkg::DATA_W-1:0] cap_data;       // Sampler to BIST mux
    logic                       cap_valid;
    logic                       fifo_wr_en;     // BIST mux to FIFO
    logic [dsp_pkg::DATA_W-1:0] fifo_wr_data;
    logic                       fifo_rd_en;     // FIFO to engine
    logic [dsp_pkg::DATA_W-1:0] fifo_rd_data;
    logic                       fifo_empty;
    logic                       fifo_full;

    adc_sampler u_sampler (
        .clk(clk), .reset(reset), .div_sel(div_sel),
        .adc_data(adc_data), .adc_valid(adc_valid),
        .cap_data(cap_data), .cap_valid(cap_valid)
    );

    // ==========================================================
    // Input select, buffering and filter
    // ==========================================================
    bist_ctrl u_bist (
        .clk(clk), .reset(reset), .bist_start(bist_start),
        .cap_data(cap_data), .cap_valid(cap_valid),
        .fifo_full(fifo_full), .fifo_empty(fifo_empty), .fir_busy(dsp_busy),
        .dsp_out(dsp_out), .dsp_valid(dsp_valid),
        .wr_en(fifo_wr_en), .wr_data(fifo_wr_data),
        .bist_active(bist_active), .bist_done(bist_done),
        .bist_signature(bist_signature)
    );

    sample_fifo u_fifo (
        .clk(clk), .reset(reset),
        .wr_en(fifo_wr_en), .wr_data(fifo_wr_data),
        .rd_en(fifo_rd_en), .rd_data(fifo_rd_data),
        .empty(fifo_empty), .full(fifo_full), .overrun(overrun)
    );

    fir_engine u_fir (
        .clk(clk), .reset(reset),
        .fifo_empty(fifo_empty), .fifo_data(fifo_rd_data), .fifo_rd(fifo_rd_en),
        .coeff_load(coeff_load), .coeff_addr(coeff_addr), .coeff_data(coeff_data),
        .dsp_out(dsp_out), .dsp_valid(dsp_valid), .busy(dsp_busy)
    );

endmodule

`default_nettype wire

//--- bench/dsp_top_props.sv
// Concurrent checks on the DSP top level, bound into dsp_top.
// Output pulse shape, FIR busy window, BIST handover and BIST write drops.

`timescale 1ns/1ps
`default_nettype none

module dsp_top_props (
    input wire clk,
    input wire reset,
    input wire dsp_valid,
    input wire dsp_busy,
    input wire fifo_rd_en,
    input wire fifo_wr_en,
    input wire overrun,
    input wire bist_active,
    input wire bist_done
);

    int unsigned fails = 0;   // Failed assertion count

    valid_pulse: assert property (@(posedge clk) disable iff (reset)
        dsp_valid |=> !dsp_valid)
        else begin fails++; $error("dsp_valid held longer than one cycle"); end

    // Busy from cycle 1 to cycle 9 after the pop
    busy_window: assert property (@(posedge clk) disable iff (reset)
        fifo_rd_en |=> dsp_busy [*9] ##1 !dsp_busy)
        else begin fails++; $error("dsp_busy window is not 9 cycles after a pop"); end

    // Done only takes over as active drops
    bist_excl: assert property (@(posedge clk) disable iff (reset)
        $rose(bist_done) |-> $fell(bist_active))
        else begin fails++; $error("bist_done rose without bist_active falling"); end

    // Pattern writes wait for room
    inject_room: assert property (@(posedge clk) disable iff (reset)
        (fifo_wr_en && bist_active) |=> !overrun)
        else begin fails++; $error("BIST pattern written into a full FIFO"); end

endmodule

bind dsp_top dsp_top_props props_i (
    .clk(clk),
    .reset(reset),
    .dsp_valid(dsp_valid),
    .dsp_busy(dsp_busy),
    .fifo_rd_en(fifo_rd_en),
    .fifo_wr_en(fifo_wr_en),
    .overrun(overrun),
    .bist_active(bist_active),
    .bist_done(bist_done)
);

`default_nettype wire

//--- bench/dsp_top_tb.sv
// Testbench for the DSP signal path. Drives random ADC, coefficient and BIST
// traffic, runs a cycle model of the path next to the DUT and compares the
// outputs on every falling edge. Compile with vlog.f, top module dsp_top_tb.

`timescale 1ns/1ps
`default_nettype none

module dsp_top_tb;

    localparam int RUN_CYCLES  = 11 + 8 + 300 + 4 * 160 + 121 + 60 + 1000 + 10;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 500) * 20;  // Phases plus margin

    logic                  clk = 1'b0;
    logic                  reset;
    ctrl_pkg::div_sel_t    div_sel;
    logic [15:0]           adc_data;
    logic                  adc_valid;
    logic                  coeff_load;
    logic [2:0]            coeff_addr;
    logic [15:0]           coeff_data;
    logic                  bist_start;
    logic [15:0]           dsp_out;
    logic                  dsp_valid;
    logic                  dsp_busy;
    logic                  overrun;
    logic                  bist_active;
    logic                  bist_done;
    logic [15:0]           bist_signature;

    // ==========================================================
    // Reference model state
    // ==========================================================
    int                    m_cnt;          // Divider count
    ctrl_pkg::div_sel_t    m_dsel_q;
    logic                  m_capv;
    logic [15:0]           m_capd;
    logic [15:0]           m_q[$];         // FIFO contents, head first
    logic                  m_ovr;
    int                    m_ph;           // 0 idle, 1..8 MAC, 9 output
    logic signed [15:0]    m_cb[8];        // Written coefficients
    logic signed [15:0]    m_ca[8];        // Coefficients of the last pop
    logic signed [15:0]    m_dly[8];
    logic [15:0]           m_out;
    ctrl_pkg::bist_state_t m_bst;
    logic [15:0]           m_lfsr;
    int                    m_pat;
    logic [15:0]           m_sig;
    int                    errors;
    int                    checks;
    int                    dut_pulses;
    int                    mdl_pulses;
    int                    dut_ovr;
    int                    mdl_ovr;

    dsp_top dsp_top_i (.*);

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    // Advance n rising edges and sit 2 ns past the last one
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin : model
        int          n;
        logic        chg;
        logic        strobe;
        logic        full;
        logic        empty;
        logic        busy;
        logic        rd;
        logic        patwr;
        logic        adc_pass;
        logic        wr;
        logic [15:0] wdata;
        logic [15:0] head;
        longint      acc;
        n = 2 << int'(div_sel);                        // Strobe period
        if (reset) begin
            m_cnt = 0;
            m_dsel_q = div_sel;
            m_capv = 1'b0;
            m_capd = '0;
            m_q.delete();
            m_ovr = 1'b0;
            m_ph = 0;
            m_out = '0;
            for (int k = 0; k < 8; k++) begin
                m_cb[k] = '0;
                m_ca[k] = '0;
                m_dly[k] = '0;
            end
            m_bst = ctrl_pkg::BIST_IDLE;
            m_lfsr = 16'hace1;
            m_pat = 0;
            m_sig = '0;
        end else begin
            chg      = div_sel != m_dsel_q;
            strobe   = (m_cnt == n - 1) && !chg;
            full     = m_q.size() == 4;
            empty    = m_q.size() == 0;
            busy     = m_ph != 0;
            rd       = !busy && !empty;                 // Pop when idle
            patwr    = (m_bst == ctrl_pkg::BIST_RUN) && !full;
            adc_pass = (m_bst == ctrl_pkg::BIST_IDLE) || (m_bst == ctrl_pkg::BIST_DONE);
            wr       = patwr || (adc_pass && m_capv);
            wdata    = (m_bst == ctrl_pkg::BIST_RUN) ? m_lfsr : m_capd;
            head     = '0;
            if (!adc_pass && m_ph == 9) begin
                m_sig = {m_sig[14:0], m_sig[15]} ^ m_out;   // Rotate then fold
            end
            // Sampler
            m_dsel_q = div_sel;
            m_capv = strobe && adc_valid;
            if (m_capv) m_capd = adc_data;
            m_cnt = (strobe || chg) ? 0 : m_cnt + 1;
            // FIFO where full drops the write
            if (rd) head = m_q.pop_front();
            if (wr && !full) m_q.push_back(wdata);
            m_ovr = wr && full;
            // Engine result is known at the pop
            if (rd) begin
                for (int k = 7; k > 0; k--) m_dly[k] = m_dly[k-1];
                m_dly[0] = head;
                acc = 0;
                for (int k = 0; k < 8; k++) begin
                    m_ca[k] = m_cb[k];
                    acc += longint'(m_ca[k]) * longint'(m_dly[k]);
                end
                m_out = 16'(acc >>> 15);
                m_ph = 1;
            end else if (m_ph == 9) begin
                m_ph = 0;
            end else if (busy) begin
                m_ph++;
            end
            if (coeff_load) m_cb[coeff_addr] = coeff_data;   // Used from next pop
            // BIST sequence
            case (m_bst)
                ctrl_pkg::BIST_RUN: begin
                    if (patwr) begin
                        m_lfsr = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[13] ^ m_lfsr[12] ^ m_lfsr[10]};
                        m_pat++;
                        if (m_pat == 32) m_bst = ctrl_pkg::BIST_DRAIN;
                    end
                end
                ctrl_pkg::BIST_DRAIN: if (empty && !busy) m_bst = ctrl_pkg::BIST_DONE;
                default: begin
                    if (bist_start) begin
                        m_bst = ctrl_pkg::BIST_RUN;
                        m_lfsr = 16'hace1;
                        m_pat = 0;
                        m_sig = '0;
                    end
                end
            endcase
        end
    end

    // ==========================================================
    // Compare on the falling edge when all is settled
    // ==========================================================
    always @(negedge clk) begin
        if (m_ph == 9) mdl_pulses++;
        if (dsp_valid) dut_pulses++;
        if (m_ovr) mdl_ovr++;
        if (overrun) dut_ovr++;
        check("dsp_valid", 32'(m_ph == 9), 32'(dsp_valid));
        check("dsp_busy", 32'(m_ph != 0), 32'(dsp_busy));
        if (m_ph == 9) check("dsp_out", 32'(m_out), 32'(dsp_out));
        check("overrun", 32'(m_ovr), 32'(overrun));
        check("bist_active", 32'(m_bst == ctrl_pkg::BIST_RUN || m_bst == ctrl_pkg::BIST_DRAIN),
              32'(bist_active));
        check("bist_done", 32'(m_bst == ctrl_pkg::BIST_DONE), 32'(bist_done));
        check("bist_signature", 32'(m_sig), 32'(bist_signature));
    end

    initial begin : stimulus
        int wait_cnt;
        void'($urandom(32'hfb2b6bc7));
        errors = 0;
        checks = 0;
        reset = 1'b1;
        div_sel = ctrl_pkg::DIV_16;
        adc_data = '0;
        adc_valid = 1'b0;
        coeff_load = 1'b0;
        coeff_addr = '0;
        coeff_data = '0;
        bist_start = 1'b0;
        step(10);
        reset = 1'b0;
        step(1);
        check("dsp_valid after reset", 32'(0), 32'(dsp_valid));   // Reset state
        check("dsp_busy after reset", 32'(0), 32'(dsp_busy));
        check("overrun after reset", 32'(0), 32'(overrun));
        check("bist_active after reset", 32'(0), 32'(bist_active));
        check("bist_done after reset", 32'(0), 32'(bist_done));
        // Coefficients then filtered ADC traffic at DIV_16
        for (int k = 0; k < 8; k++) begin
            coeff_load = 1'b1;
            coeff_addr = 3'(k);
            coeff_data = 16'($urandom);
            step(1);
        end
        coeff_load = 1'b0;
        repeat (300) begin
            adc_valid = 1'($urandom);
            adc_data = 16'($urandom);
            step(1);
        end
        // Pulse count per divide ratio
        adc_valid = 1'b1;
        for (int d = 0; d < 4; d++) begin
            div_sel = ctrl_pkg::div_sel_t'(d);
            dut_pulses = 0;
            mdl_pulses = 0;
            repeat (160) begin
                adc_data = 16'($urandom);
                step(1);
            end
            check("dsp_valid pulse count", 32'(mdl_pulses), 32'(dut_pulses));
        end
        // Overrun at DIV_2 with one coefficient rewritten on the way
        div_sel = ctrl_pkg::DIV_2;
        dut_ovr = 0;
        mdl_ovr = 0;
        coeff_load = 1'b1;
        coeff_addr = 3'($urandom);
        coeff_data = 16'($urandom);
        step(1);
        coeff_load = 1'b0;
        repeat (120) begin
            adc_data = 16'($urandom);
            step(1);
        end
        check("overrun pulse count", 32'(mdl_ovr), 32'(dut_ovr));
        if (mdl_ovr == 0) begin
            errors++;
            $display("The overrun phase never filled the FIFO, no write was dropped");
        end
        adc_valid = 1'b0;
        step(60);
        // BIST run
        bist_start = 1'b1;
        step(1);
        bist_start = 1'b0;
        check("bist_active at start", 32'(1), 32'(bist_active));
        wait_cnt = 0;
        while (!bist_done && wait_cnt < 1000) begin
            step(1);
            wait_cnt++;
        end
        if (!bist_done) begin
            errors++;
            $display("BIST did not reach its done state within 1000 cycles");
        end
        check("bist_active at done", 32'(0), 32'(bist_active));
        check("bist_signature at done", 32'(m_sig), 32'(bist_signature));
        step(10);
        check("assertion failures", 32'(0), 32'(dsp_top_i.props_i.fails));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/dsp_pkg.sv
design/ctrl_pkg.sv
design/adc_sampler.sv
design/sample_fifo.sv
design/fir_engine.sv
design/bist_ctrl.sv
design/dsp_top.sv
bench/dsp_top_props.sv
bench/dsp_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= dsp_top_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
